// ==== vertex_pagerank.f ====
design/pagerank_pkg.sv
design/cmd_fifo.sv
design/vertex_job_ctrl.sv
design/read_arbiter_wb.sv
design/edge_data_ctrl.sv
design/vertex_pagerank_top.sv
bench/clock_gen.sv
bench/tb_vertex_pagerank.sv

// ==== Bender.yml ====
package:
  name: vertex_pagerank

sources:
  - files:
      - design/pagerank_pkg.sv
      - design/cmd_fifo.sv
      - design/vertex_job_ctrl.sv
      - design/read_arbiter_wb.sv
      - design/edge_data_ctrl.sv
      - design/vertex_pagerank_top.sv
  - target: test
    files:
      - bench/clock_gen.sv
      - bench/tb_vertex_pagerank.sv

// ==== bench/tb_vertex_pagerank.sv ====
// Memory model answers only the edge window and the first 64 rank words; one job stream
`timescale 1ns/1ps
`default_nettype none

module tb_vertex_pagerank;

	localparam pagerank_pkg::addr_t EDGE_BASE = 32'h0000_1000;
	localparam pagerank_pkg::addr_t RANK_BASE = 32'h0000_8000;
	localparam pagerank_pkg::addr_t EDGE_SPAN = 32'h0000_0100;
	localparam int                  NUM_JOBS  = 5;

	logic                       clock;
	logic                       rstn;
	logic                       vertex_job_request;
	logic                       wb_ack;
	logic                       exp_avail;
	logic                       slave_busy;
	pagerank_pkg::vertex_job_t  vertex_job;
	pagerank_pkg::wb_req_t      wb_req;
	pagerank_pkg::rank_t        wb_dat;
	pagerank_pkg::edge_data_t   edge_data;
	pagerank_pkg::vertex_t      vertex_num_counter;
	pagerank_pkg::vertex_t      edge_num_counter;
	pagerank_pkg::edge_data_t   exp_q[$];
	pagerank_pkg::edge_data_t   exp_head;
	integer                     seed;
	int                         error_count;
	int                         bus_errors;
	int                         records_checked;
	int                         jobs_sent;
	int                         total_edges;
	int                         cycle_count;
	int                         cycle_limit;
	int                         wait_left;
	int                         errs_before;
	int                         degrees [NUM_JOBS];

	clock_gen #(.RESET_CYCLES(10)) clock_gen_inst (.clock(clock), .rstn(rstn));

	vertex_pagerank_top #(.EDGE_BASE(EDGE_BASE), .RANK_BASE(RANK_BASE)) DUT (
		.clock             (clock             ),
		.rstn              (rstn              ),
		.vertex_job        (vertex_job        ),
		.vertex_job_request(vertex_job_request),
		.wb_req            (wb_req            ),
		.wb_dat            (wb_dat            ),
		.wb_ack            (wb_ack            ),
		.edge_data         (edge_data         ),
		.vertex_num_counter(vertex_num_counter),
		.edge_num_counter  (edge_num_counter  )
	);

	function automatic pagerank_pkg::rank_t mem_word(input pagerank_pkg::addr_t adr);
		pagerank_pkg::addr_t n;
		if (adr >= RANK_BASE) begin
			n = adr - RANK_BASE;
			return n * 32'd3 + 32'd1;
		end
		n = adr - EDGE_BASE;
		return (n * 32'd7) % 32'd64;
	endfunction

	function automatic logic addr_in_map(input pagerank_pkg::addr_t adr);
		return ((adr >= EDGE_BASE) && (adr < EDGE_BASE + EDGE_SPAN)) ||
			((adr >= RANK_BASE) && (adr < RANK_BASE + 32'd64));
	endfunction

	task automatic note_error(input string msg);
		$display("Error: %0t %s", $time, msg);
		error_count++;
	endtask

	task automatic report_test(input string name, input int errs);
		$display("Test %s finished with %0d errors", name, error_count - errs);
	endtask

	task automatic refresh_head();
		exp_avail = (exp_q.size() != 0);
		if (exp_avail) begin
			exp_head = exp_q[0];
		end else begin
			exp_head = '0;
		end
	endtask

	// Queues the expected records, then offers the job on the next request
	task automatic send_job(input pagerank_pkg::vertex_t vid, input pagerank_pkg::addr_t start,
			input int deg);
		pagerank_pkg::edge_data_t rec;
		pagerank_pkg::vertex_t    n;
		for (int i = 0; i < deg; i++) begin
			n         = start + i;
			rec.valid = 1'b1;
			rec.src   = vid;
			rec.dst   = (n * 32'd7) % 32'd64;
			rec.rank  = rec.dst * 32'd3 + 32'd1;
			exp_q.push_back(rec);
		end
		refresh_head();
		while (!vertex_job_request) begin
			@(negedge clock);
		end
		vertex_job.valid      = 1'b1;
		vertex_job.vertex_id  = vid;
		vertex_job.edge_start = start;
		vertex_job.out_degree = deg;
		@(negedge clock);
		vertex_job = '0;
		jobs_sent++;
	endtask

	task automatic wait_for_edges(input int total);
		while (edge_num_counter != total) begin
			@(negedge clock);
		end
		@(negedge clock);
	endtask

	////////////////////
	// Wishbone memory
	////////////////////

	always @(negedge clock) begin
		if (!rstn) begin
			wb_ack     = 1'b0;
			slave_busy = 1'b0;
		end else if (wb_ack) begin
			wb_ack     = 1'b0;
			slave_busy = 1'b0;
		end else if (wb_req.cyc && wb_req.stb) begin
			if (!slave_busy) begin
				slave_busy = 1'b1;
				wait_left  = {$random(seed)} % 4;
			end
			if (wait_left == 0) begin
				wb_ack = 1'b1;
				wb_dat = mem_word(wb_req.adr);
			end else begin
				wait_left--;
			end
		end
	end

	////////////////////
	// Scoreboard and checks
	////////////////////

	// Pops in the active region, so the assertions still see the old head
	always @(posedge clock) begin
		if (rstn && edge_data.valid && exp_avail) begin
			void'(exp_q.pop_front());
			records_checked++;
			refresh_head();
		end
	end

	a_record: assert property (@(posedge clock) disable iff (!rstn)
		edge_data.valid |-> exp_avail && (edge_data == exp_head))
		else begin
			$display("Error: %0t record %0d->%0d rank %0d, expected %0d->%0d rank %0d", $time,
				$sampled(edge_data.src), $sampled(edge_data.dst), $sampled(edge_data.rank),
				$sampled(exp_head.src), $sampled(exp_head.dst), $sampled(exp_head.rank));
			error_count++;
		end

	a_stb_cyc: assert property (@(posedge clock) wb_req.stb |-> wb_req.cyc)
		else begin
			$display("Error: %0t stb high without cyc", $time);
			error_count++;
			bus_errors++;
		end

	a_adr_hold: assert property (@(posedge clock) disable iff (!rstn)
		wb_req.stb && !wb_ack |=> wb_req.stb && $stable(wb_req.adr) && !wb_req.we)
		else begin
			$display("Error: %0t transfer dropped or adr changed before ack", $time);
			error_count++;
			bus_errors++;
		end

	a_adr_map: assert property (@(posedge clock) disable iff (!rstn)
		wb_req.stb |-> !wb_req.we && addr_in_map(wb_req.adr))
		else begin
			$display("Error: %0t bad read at adr %h", $time, $sampled(wb_req.adr));
			error_count++;
			bus_errors++;
		end

	// Held state during reset and at the first edge after it
	a_reset_state: assert property (@(posedge clock) (!rstn || $rose(rstn)) |->
		!wb_req.cyc && !wb_req.stb && !edge_data.valid && !vertex_job_request &&
		(vertex_num_counter == '0) && (edge_num_counter == '0))
		else begin
			$display("Error: %0t outputs not in reset state", $time);
			error_count++;
		end

	a_request_up: assert property (@(posedge clock) $rose(rstn) |=> vertex_job_request)
		else begin
			$display("Error: %0t vertex_job_request still low after reset", $time);
			error_count++;
		end

	always @(posedge clock) begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= cycle_limit) begin
			$display("Run stopped: no completion within %0d cycles", cycle_limit);
			$display("tests failed");
			$finish;
		end
	end

	////////////////////
	// Stimulus
	////////////////////

	initial begin
		seed            = 32'h38bb_9742;
		vertex_job      = '0;
		wb_ack          = 1'b0;
		wb_dat          = '0;
		error_count     = 0;
		bus_errors      = 0;
		records_checked = 0;
		jobs_sent       = 0;
		cycle_count     = 0;
		total_edges     = 3;
		for (int j = 0; j < NUM_JOBS; j++) begin
			degrees[j]  = 1 + ({$random(seed)} % 6);
			total_edges = total_edges + degrees[j];
		end
		cycle_limit = total_edges * 24 + 200;
		refresh_head();

		@(posedge rstn);
		repeat (2) @(negedge clock);
		report_test("reset_state", 0);

		errs_before = error_count;
		send_job(32'd5, 32'd2, 3);
		wait_for_edges(3);
		assert (exp_q.size() == 0) else note_error("single job left records missing");
		report_test("single_job", errs_before);

		errs_before = error_count;
		send_job(32'd9, 32'd0, 0);
		assert (vertex_num_counter == 32'd2)
			else note_error($sformatf("vertex count %0d, expected 2", vertex_num_counter));
		assert (vertex_job_request) else note_error("request low after zero-degree job");
		repeat (8) @(negedge clock);
		assert (edge_num_counter == 32'd3) else note_error("zero-degree job made a record");
		report_test("zero_degree", errs_before);

		errs_before = error_count;
		for (int j = 0; j < NUM_JOBS; j++) begin
			send_job(32'd20 + j, 32'd10 + 8 * j, degrees[j]);
		end
		wait_for_edges(total_edges);
		assert (exp_q.size() == 0) else note_error("back-to-back jobs left records missing");
		report_test("back_to_back", errs_before);
		$display("Test bus_protocol finished with %0d errors", bus_errors);

		errs_before = error_count;
		assert (vertex_num_counter == jobs_sent)
			else note_error($sformatf("vertex count %0d, expected %0d", vertex_num_counter,
				jobs_sent));
		assert (edge_num_counter == total_edges)
			else note_error($sformatf("edge count %0d, expected %0d", edge_num_counter,
				total_edges));
		assert (records_checked == total_edges)
			else note_error($sformatf("%0d records seen, expected %0d", records_checked,
				total_edges));
		report_test("counters", errs_before);

		$display("Summary: %0d jobs, %0d records checked, %0d errors", jobs_sent,
			records_checked, error_count);
		if (error_count == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== bench/clock_gen.sv ====
// Fixed 20 ns clock starting low; rstn is released on a falling edge after RESET_CYCLES edges
`timescale 1ns/1ps
`default_nettype none

module clock_gen #(
	parameter int RESET_CYCLES = 10
) (
	output logic clock,
	output logic rstn
);

	initial begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	// Release away from the sampling edge
	initial begin
		rstn = 1'b0;
		repeat (RESET_CYCLES) @(posedge clock);
		@(negedge clock);
		rstn = 1'b1;
	end

endmodule

`default_nettype wire

// ==== design/vertex_pagerank_top.sv ====
// Read path only; EDGE_BASE and RANK_BASE regions must not overlap in the attached memory
`timescale 1ns/1ps
`default_nettype none

module vertex_pagerank_top #(
	parameter int                  CMD_DEPTH  = 8,
	parameter int                  THROTTLE_W = 2,
	parameter pagerank_pkg::addr_t EDGE_BASE  = 32'h0000_1000,
	parameter pagerank_pkg::addr_t RANK_BASE  = 32'h0000_8000
) (
	input  logic                      clock             ,
	input  logic                      rstn              ,
	input  pagerank_pkg::vertex_job_t vertex_job        ,
	output logic                      vertex_job_request,
	output pagerank_pkg::wb_req_t     wb_req            ,
	input  pagerank_pkg::rank_t       wb_dat            ,
	input  logic                      wb_ack            ,
	output pagerank_pkg::edge_data_t  edge_data         ,
	output pagerank_pkg::vertex_t     vertex_num_counter,
	output pagerank_pkg::vertex_t     edge_num_counter
);

	pagerank_pkg::read_cmd_t edge_cmd;
	pagerank_pkg::read_cmd_t edge_head;
	pagerank_pkg::read_cmd_t data_cmd;
	pagerank_pkg::read_cmd_t data_head;
	pagerank_pkg::read_rsp_t rsp;
	logic                    edge_full;
	logic                    edge_empty;
	logic                    edge_pop;
	logic                    data_empty;
	logic                    data_alfull;
	logic                    data_pop;

	////////////////////
	// Edge reads
	////////////////////

	vertex_job_ctrl #(.EDGE_BASE(EDGE_BASE)) vertex_job_ctrl_inst (
		.clock             (clock             ),
		.rstn              (rstn              ),
		.vertex_job        (vertex_job        ),
		.vertex_job_request(vertex_job_request),
		.edge_cmd          (edge_cmd          ),
		.edge_cmd_full     (edge_full         ),
		.vertex_num_counter(vertex_num_counter)
	);

	cmd_fifo #(.CMD_DEPTH(CMD_DEPTH)) edge_cmd_queue (
		.clock   (clock         ),
		.rstn    (rstn          ),
		.push    (edge_cmd.valid),
		.data_in (edge_cmd      ),
		.pop     (edge_pop      ),
		.data_out(edge_head     ),
		.empty   (edge_empty    ),
		.full    (edge_full     ),
		.alfull  (              )
	);

	////////////////////
	// Rank reads
	////////////////////

	cmd_fifo #(.CMD_DEPTH(CMD_DEPTH)) data_cmd_queue (
		.clock   (clock         ),
		.rstn    (rstn          ),
		.push    (data_cmd.valid),
		.data_in (data_cmd      ),
		.pop     (data_pop      ),
		.data_out(data_head     ),
		.empty   (data_empty    ),
		.full    (              ),
		.alfull  (data_alfull   )
	);

	read_arbiter_wb #(.THROTTLE_W(THROTTLE_W)) read_arbiter_wb_inst (
		.clock      (clock      ),
		.rstn       (rstn       ),
		.edge_head  (edge_head  ),
		.data_head  (data_head  ),
		.edge_empty (edge_empty ),
		.data_empty (data_empty ),
		.data_alfull(data_alfull),
		.edge_pop   (edge_pop   ),
		.data_pop   (data_pop   ),
		.wb_req     (wb_req     ),
		.wb_dat     (wb_dat     ),
		.wb_ack     (wb_ack     ),
		.rsp        (rsp        )
	);

	edge_data_ctrl #(.RANK_BASE(RANK_BASE)) edge_data_ctrl_inst (
		.clock           (clock           ),
		.rstn            (rstn            ),
		.rsp             (rsp             ),
		.data_cmd        (data_cmd        ),
		.edge_data       (edge_data       ),
		.edge_num_counter(edge_num_counter)
	);

endmodule

`default_nettype wire

// ==== design/edge_data_ctrl.sv ====
// Responses arrive in order with no back-pressure; records are dropped if nobody samples them
`timescale 1ns/1ps
`default_nettype none

module edge_data_ctrl #(
	parameter pagerank_pkg::addr_t RANK_BASE = 32'h0000_8000
) (
	input  logic                     clock           ,
	input  logic                     rstn            ,
	input  pagerank_pkg::read_rsp_t  rsp             ,
	output pagerank_pkg::read_cmd_t  data_cmd        ,
	output pagerank_pkg::edge_data_t edge_data       ,
	output pagerank_pkg::vertex_t    edge_num_counter
);

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			data_cmd         <= '0;
			edge_data        <= '0;
			edge_num_counter <= '0;
		end else begin
			data_cmd.valid  <= 1'b0;
			edge_data.valid <= 1'b0;
			if (rsp.valid) begin
				case (rsp.cmd.kind)
					// Edge word names the destination whose rank is read next
					pagerank_pkg::EDGE_ARRAY: begin
						data_cmd <= '{
							valid: 1'b1,
							kind:  pagerank_pkg::GRAPH_DATA,
							addr:  RANK_BASE + rsp.word.edge_dst,
							src:   rsp.cmd.src,
							dst:   rsp.word.edge_dst
						};
					end
					// Rank word closes the edge
					pagerank_pkg::GRAPH_DATA: begin
						edge_data <= '{
							valid: 1'b1,
							src:   rsp.cmd.src,
							dst:   rsp.cmd.dst,
							rank:  rsp.word.rank
						};
						edge_num_counter <= edge_num_counter + 32'd1;
					end
				endcase
			end
		end
	end

endmodule

`default_nettype wire

// ==== design/read_arbiter_wb.sv ====
// Wishbone classic read master, one transfer in flight, no error or retry handling
`timescale 1ns/1ps
`default_nettype none

module read_arbiter_wb #(
	parameter int THROTTLE_W = 2
) (
	input  logic                    clock      ,
	input  logic                    rstn       ,
	input  pagerank_pkg::read_cmd_t edge_head  ,
	input  pagerank_pkg::read_cmd_t data_head  ,
	input  logic                    edge_empty ,
	input  logic                    data_empty ,
	input  logic                    data_alfull,
	output logic                    edge_pop   ,
	output logic                    data_pop   ,
	output pagerank_pkg::wb_req_t   wb_req     ,
	input  pagerank_pkg::rank_t     wb_dat     ,
	input  logic                    wb_ack     ,
	output pagerank_pkg::read_rsp_t rsp
);

	logic [THROTTLE_W-1:0]   throttle;
	logic                    last_data;
	logic                    can_start;
	logic                    edge_req;
	logic                    data_req;
	logic                    grant_edge;
	logic                    grant_data;
	logic                    done;
	pagerank_pkg::read_cmd_t cur_cmd;

	////////////////////
	// Grant
	////////////////////

	assign can_start = !wb_req.cyc && (throttle == '0);
	// Edge reads wait until the rank queue can take the read they cause
	assign edge_req  = !edge_empty && !data_alfull;
	assign data_req  = !data_empty;

	assign grant_edge = can_start && edge_req && (!data_req || last_data);
	assign grant_data = can_start && data_req && (!edge_req || !last_data);
	assign edge_pop   = grant_edge;
	assign data_pop   = grant_data;
	assign done       = wb_req.cyc && wb_req.stb && wb_ack;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			throttle  <= '0;
			last_data <= 1'b0;
		end else begin
			throttle <= throttle + 1'b1;
			if (grant_edge || grant_data) begin
				last_data <= grant_data;
			end
		end
	end

	////////////////////
	// Bus cycle
	////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wb_req <= '0;
		end else begin
			wb_req.we <= 1'b0;
			if (done) begin
				wb_req.cyc <= 1'b0;
				wb_req.stb <= 1'b0;
			end else if (grant_edge || grant_data) begin
				wb_req.cyc <= 1'b1;
				wb_req.stb <= 1'b1;
				wb_req.adr <= grant_edge ? edge_head.addr : data_head.addr;
			end
		end
	end

	// Held for the whole transfer so the response can echo it
	always_ff @(posedge clock) begin
		if (grant_edge) begin
			cur_cmd <= edge_head;
		end else if (grant_data) begin
			cur_cmd <= data_head;
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			rsp <= '0;
		end else begin
			rsp.valid <= done;
			if (done) begin
				rsp.cmd  <= cur_cmd;
				rsp.word <= pagerank_pkg::read_word_u'(wb_dat);
			end
		end
	end

	a_stb_hold: assert property (@(posedge clock) disable iff (!rstn)
		wb_req.stb && !wb_ack |=> wb_req.stb && $stable(wb_req.adr));
	a_read_only: assert property (@(posedge clock) disable iff (!rstn) !wb_req.we);

endmodule

`default_nettype wire

// ==== design/vertex_job_ctrl.sv ====
// One job at a time; edge reads are pushed one per cycle, a zero-degree job completes at once
`timescale 1ns/1ps
`default_nettype none

module vertex_job_ctrl #(
	parameter pagerank_pkg::addr_t EDGE_BASE = 32'h0000_1000
) (
	input  logic                      clock             ,
	input  logic                      rstn              ,
	input  pagerank_pkg::vertex_job_t vertex_job        ,
	output logic                      vertex_job_request,
	output pagerank_pkg::read_cmd_t   edge_cmd          ,
	input  logic                      edge_cmd_full     ,
	output pagerank_pkg::vertex_t     vertex_num_counter
);

	logic                      take;
	logic                      push;
	logic                      last_edge;
	logic                      busy;
	logic                      busy_next;
	pagerank_pkg::vertex_job_t job_q;
	pagerank_pkg::vertex_t     edge_idx;

	assign take      = vertex_job.valid && vertex_job_request;
	assign push      = busy && !edge_cmd_full;
	assign last_edge = (edge_idx == job_q.out_degree - 32'd1);

	always_comb begin
		busy_next = busy;
		if (take && (vertex_job.out_degree != '0)) begin
			busy_next = 1'b1;
		end else if (push && last_edge) begin
			busy_next = 1'b0;
		end
	end

	////////////////////
	// Job state and vertex count
	////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			busy               <= 1'b0;
			vertex_job_request <= 1'b0;
			edge_idx           <= '0;
			vertex_num_counter <= '0;
		end else begin
			busy               <= busy_next;
			vertex_job_request <= !busy_next;
			if (take) begin
				edge_idx <= '0;
			end else if (push) begin
				edge_idx <= edge_idx + 32'd1;
			end
			// Vertex done once its last edge read is queued
			if ((take && (vertex_job.out_degree == '0)) || (push && last_edge)) begin
				vertex_num_counter <= vertex_num_counter + 32'd1;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (take) begin
			job_q <= vertex_job;
		end
	end

	always_comb begin
		edge_cmd       = '0;
		edge_cmd.valid = push;
		edge_cmd.kind  = pagerank_pkg::EDGE_ARRAY;
		edge_cmd.addr  = EDGE_BASE + job_q.edge_start + edge_idx;
		edge_cmd.src   = job_q.vertex_id;
	end

	// Pushes go only into a queue with room and stay inside the job's edge range
	a_push_ok: assert property (@(posedge clock) disable iff (!rstn)
		edge_cmd.valid |-> !edge_cmd_full && (edge_idx < job_q.out_degree));

endmodule

`default_nettype wire

// ==== design/cmd_fifo.sv ====
// First-word fall-through queue; data_out is only meaningful while empty is low
`timescale 1ns/1ps
`default_nettype none

module cmd_fifo #(
	parameter int CMD_DEPTH = 8
) (
	input  logic                    clock   ,
	input  logic                    rstn    ,
	input  logic                    push    ,
	input  pagerank_pkg::read_cmd_t data_in ,
	input  logic                    pop     ,
	output pagerank_pkg::read_cmd_t data_out,
	output logic                    empty   ,
	output logic                    full    ,
	output logic                    alfull
);

	localparam int PTR_W = (CMD_DEPTH > 1) ? $clog2(CMD_DEPTH) : 1;
	localparam int CNT_W = $clog2(CMD_DEPTH + 1);
	localparam logic [PTR_W-1:0] LAST_SLOT = PTR_W'(CMD_DEPTH - 1);

	pagerank_pkg::read_cmd_t mem [CMD_DEPTH];
	logic [PTR_W-1:0]        wr_ptr;
	logic [PTR_W-1:0]        rd_ptr;
	logic [CNT_W-1:0]        count;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push) begin
				wr_ptr <= (wr_ptr == LAST_SLOT) ? '0 : wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= (rd_ptr == LAST_SLOT) ? '0 : rd_ptr + 1'b1;
			end
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (push) begin
			mem[wr_ptr] <= data_in;
		end
	end

	assign data_out = mem[rd_ptr];
	assign empty    = (count == '0);
	assign full     = (count == CNT_W'(CMD_DEPTH));
	// At most one free slot
	assign alfull   = (count >= CNT_W'(CMD_DEPTH - 1));

	a_no_overflow:  assert property (@(posedge clock) disable iff (!rstn) push |-> !full);
	a_no_underflow: assert property (@(posedge clock) disable iff (!rstn) pop |-> !empty);

endmodule

`default_nettype wire

// ==== design/pagerank_pkg.sv ====
// Word-addressed 32-bit memory; vertex ids, ranks and addresses all fit one bus word
`default_nettype none

package pagerank_pkg;

	typedef logic [31:0] addr_t;
	typedef logic [31:0] vertex_t;
	typedef logic [31:0] rank_t;

	// Target structure of a read
	typedef enum logic {
		EDGE_ARRAY = 1'b0,
		GRAPH_DATA = 1'b1
	} read_kind_e;

	typedef struct packed {
		logic    valid;
		vertex_t vertex_id;
		addr_t   edge_start;
		vertex_t out_degree;
	} vertex_job_t;

	// dst is zero on edge array reads
	typedef struct packed {
		logic       valid;
		read_kind_e kind;
		addr_t      addr;
		vertex_t    src;
		vertex_t    dst;
	} read_cmd_t;

	// One returned word, read by the echoed kind
	typedef union packed {
		vertex_t edge_dst;
		rank_t   rank;
	} read_word_u;

	typedef struct packed {
		logic       valid;
		read_cmd_t  cmd;
		read_word_u word;
	} read_rsp_t;

	typedef struct packed {
		logic    valid;
		vertex_t src;
		vertex_t dst;
		rank_t   rank;
	} edge_data_t;

	typedef struct packed {
		logic  cyc;
		logic  stb;
		logic  we;
		addr_t adr;
	} wb_req_t;

endpackage

`default_nettype wire
